// ==== build.f ====
+incdir+dv
hw/blend_pkg.sv
hw/blend_stage_if.sv
hw/blend_prod_if.sv
hw/blend_unpack.sv
hw/channel_mult.sv
hw/blend_mix.sv
hw/blend_output.sv
hw/video_blend.sv
dv/tb_video_blend.sv

// ==== dv/tb_blend_ref.svh ====
// blender reference model with LFSR stepping and the value compare

// one Galois step, feedback mask for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

// one channel of both layers, nibble in and nibble out
function automatic nib_t channel_ref(input nib_t ca, input nib_t cb,
                                     input int wa, input int wb, input logic sat);
    int fa;
    int fb;
    int s;
    fa = (int'(ca) * 17 * wa) >> 9;                 // replicated nibble = n * 17, keep 7 bits
    fb = (int'(cb) * 17 * wb) >> 9;
    s  = fa + fb;                                   // up to 8 bits
    if (sat && s > 127) begin
        s = 127;                                    // pinned
    end else begin
        s = s % 128;                                // carry lost
    end
    return nib_t'(s >> 3);                          // top 4 of 7
endfunction

function automatic rgb_t blend_ref(input argb_t a, input argb_t b, input logic de);
    int   wa;
    int   wb;
    logic sat;
    rgb_t res;
    sat = a.a[3];                                   // A bit 15
    wb  = int'(b.a) * 17;                           // B alpha as a byte
    case (a.a[3:2])
        MODE_BLEND: begin
            wa = (15 - int'(b.a)) * 17;             // inverted B alpha
        end
        MODE_OPAQUE: begin
            wa = 255;
            wb = 0;                                 // B ignored
        end
        default: begin
            wa = 255;                               // both add modes
        end
    endcase
    res.r = channel_ref(a.r, b.r, wa, wb, sat);
    res.g = channel_ref(a.g, b.g, wa, wb, sat);
    res.b = channel_ref(a.b, b.b, wa, wb, sat);
    if (!de) begin
        res = '0;                                   // blanked
    end
    return res;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("error %s expected %h actual %h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "mismatch on %s", name);
    end
endtask

// ==== dv/tb_video_blend.sv ====
// testbench for the two-layer pixel blender with directed and LFSR pixels checked against a model
`timescale 1ns/1ps

module tb_video_blend
    import blend_pkg::*;
;

    localparam int RESET_CYCLES   = 3;
    localparam int IDLE_PIXELS    = 4;                  // de low right after reset
    localparam int OPAQUE_PIXELS  = 64;
    localparam int BLEND_REPEAT   = 4;                  // pixels per B alpha value
    localparam int ADD_PIXELS     = 16;                 // per add mode
    localparam int RAND_PIXELS    = 2000;
    localparam int PIXEL_COUNT    = IDLE_PIXELS + OPAQUE_PIXELS + 16 * BLEND_REPEAT
                                  + 2 * ADD_PIXELS + RAND_PIXELS;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + PIXEL_COUNT + 50;

    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic hsync;
        logic vsync;
    } exp_t;

    logic        clk;
    logic        arst_n_i;
    argb_t       color_a_i;
    argb_t       color_b_i;
    logic        de_i;
    logic        hsync_i;
    logic        vsync_i;
    rgb_t        blend_rgb_o;
    logic        de_o;
    logic        hsync_o;
    logic        vsync_o;
    logic [31:0] lfsr_state;
    exp_t        exp_q[$];                              // in flight with oldest first
    int          n_pushed;
    int          n_checked;
    int          cycle_cnt;
    logic        stim_done;

    `include "tb_blend_ref.svh"

    video_blend dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .color_a_i   (color_a_i),
        .color_b_i   (color_b_i),
        .de_i        (de_i),
        .hsync_i     (hsync_i),
        .vsync_i     (vsync_i),
        .blend_rgb_o (blend_rgb_o),
        .de_o        (de_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o)
    );

    always #2 clk = ~clk;                               // 4 ns period

    // n bits from the LFSR with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic argb_t random_pixel();
        logic [31:0] r;
        r = rand_bits(16);
        return r[15:0];
    endfunction

    // every nibble in the upper half and A's mode set by the caller
    function automatic argb_t bright_pixel();
        logic [31:0] r;
        r = rand_bits(12);
        return {1'b1, r[11:9], 1'b1, r[8:6], 1'b1, r[5:3], 1'b1, r[2:0]};
    endfunction

    task automatic drive_pixel(input argb_t a, input argb_t b, input logic de,
                               input logic hs, input logic vs);
        @(posedge clk);
        #1;                                             // clear of the sampling edge
        color_a_i = a;
        color_b_i = b;
        de_i      = de;
        hsync_i   = hs;
        vsync_i   = vs;
    endtask

    task automatic drive_random_sync(input argb_t a, input argb_t b, input logic de);
        logic [31:0] r;
        r = rand_bits(2);
        drive_pixel(a, b, de, r[1], r[0]);
    endtask

    // model result for what the DUT samples on this edge
    always @(posedge clk) begin : push_expected
        exp_t e;
        if (arst_n_i && !stim_done) begin
            e.rgb   = blend_ref(color_a_i, color_b_i, de_i);
            e.de    = de_i;
            e.hsync = hsync_i;
            e.vsync = vsync_i;
            exp_q.push_back(e);
            n_pushed++;
        end
    end

    // outputs settled mid-cycle
    always @(negedge clk) begin : compare_outputs
        exp_t e;
        if (exp_q.size() == PIPE_LAT || (stim_done && exp_q.size() > 0)) begin
            e = exp_q.pop_front();
            check_value("blend_rgb_o", {20'h0, e.rgb}, {20'h0, blend_rgb_o});
            check_value("de_o", {31'h0, e.de}, {31'h0, de_o});
            check_value("hsync_o", {31'h0, e.hsync}, {31'h0, hsync_o});
            check_value("vsync_o", {31'h0, e.vsync}, {31'h0, vsync_o});
            n_checked++;
        end else if (arst_n_i && !stim_done) begin
            // reset state still at the outputs
            check_value("blend_rgb_o", 32'h0, {20'h0, blend_rgb_o});
            check_value("de_o", 32'h0, {31'h0, de_o});
            check_value("hsync_o", 32'h0, {31'h0, hsync_o});
            check_value("vsync_o", 32'h0, {31'h0, vsync_o});
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, run not done after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin : main_seq
        argb_t       a;
        argb_t       b;
        logic [31:0] r;
        clk        = 1'b0;
        arst_n_i   = 1'b0;
        color_a_i  = '0;
        color_b_i  = '0;
        de_i       = 1'b0;
        hsync_i    = 1'b0;
        vsync_i    = 1'b0;
        lfsr_state = 32'h77f5_6355;
        stim_done  = 1'b0;
        n_pushed   = 0;
        n_checked  = 0;
        cycle_cnt  = 0;
        a          = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        repeat (IDLE_PIXELS) begin                      // colors present while display is off
            drive_random_sync(random_pixel(), random_pixel(), 1'b0);
        end
        for (int i = 0; i < OPAQUE_PIXELS; i++) begin
            if (i % 4 == 0) begin                       // same A over four B
                a        = random_pixel();
                a.a[3:2] = MODE_OPAQUE;
            end
            drive_random_sync(a, random_pixel(), 1'b1);
        end
        for (int alpha = 0; alpha < 16; alpha++) begin
            repeat (BLEND_REPEAT) begin
                a        = random_pixel();
                a.a[3:2] = MODE_BLEND;
                b        = random_pixel();
                b.a      = nib_t'(alpha);
                drive_random_sync(a, b, 1'b1);
            end
        end
        for (int i = 0; i < 2 * ADD_PIXELS; i++) begin  // wrap half then clamp half
            a        = bright_pixel();
            a.a[3:2] = (i < ADD_PIXELS) ? MODE_ADD_WRAP : MODE_ADD_CLAMP;
            drive_random_sync(a, bright_pixel(), 1'b1);
        end
        repeat (RAND_PIXELS) begin
            a = random_pixel();
            b = random_pixel();
            r = rand_bits(1);
            drive_random_sync(a, b, r[0]);
        end
        @(posedge clk);                                 // last pixel sampled here
        #1;
        stim_done = 1'b1;
        while (n_checked != n_pushed) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== hw/blend_mix.sv ====
// stage 2, scales every channel of both layers and keeps timing in step
`timescale 1ns/1ps

module blend_mix
    import blend_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    blend_stage_if.dst  stage_i,
    blend_prod_if.src   prod_o
);

    // one multiplier pair per channel, c = 2 red, 1 green, 0 blue
    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        channel_mult u_mult (
            .clk       (clk),
            .arst_n_i  (arst_n_i),
            .col_a_i   (stage_i.col_a[c]),
            .col_b_i   (stage_i.col_b[c]),
            .alpha_a_i (stage_i.alpha_a),   // same weight for all channels
            .alpha_b_i (stage_i.alpha_b),
            .prod_a_o  (prod_o.prod_a[c]),
            .prod_b_o  (prod_o.prod_b[c])
        );
    end

    // match the multiplier register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prod_o.clamp <= 1'b0;
            prod_o.de    <= 1'b0;
            prod_o.hsync <= 1'b0;
            prod_o.vsync <= 1'b0;
        end else begin
            prod_o.clamp <= stage_i.clamp;
            prod_o.de    <= stage_i.de;
            prod_o.hsync <= stage_i.hsync;
            prod_o.vsync <= stage_i.vsync;
        end
    end

endmodule

// ==== hw/blend_output.sv ====
// stage 3, adds the scaled layers, wraps or saturates, blanks outside display
`timescale 1ns/1ps

module blend_output
    import blend_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    blend_prod_if.dst   prod_i,
    output rgb_t        blend_rgb_o,        // 12-bit result pixel
    output logic        de_o,
    output logic        hsync_o,
    output logic        vsync_o
);

    logic [SUM_W-1:0]     sum [NUM_CHAN];   // per-channel A + B, carry on top
    logic [SUM_W-2:0]     kept [NUM_CHAN];  // after wrap or clamp
    nib_t [NUM_CHAN-1:0]  nib_d;            // output nibbles, [2] red

    always_comb begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            // top 7 bits of each product, widened so the carry survives
            sum[c] = SUM_W'(prod_i.prod_a[c][PROD_SHIFT +: SUM_W-1])
                   + SUM_W'(prod_i.prod_b[c][PROD_SHIFT +: SUM_W-1]);

            if (prod_i.clamp && sum[c][SUM_W-1]) begin
                kept[c] = SAT_VAL;          // overflow pinned to max
            end else begin
                kept[c] = sum[c][SUM_W-2:0];    // carry dropped, wraps
            end

            nib_d[c] = kept[c][SUM_W-2 -: 4];   // bits 6:3
        end
    end

    // output register, black when display enable is low
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            blend_rgb_o <= '0;
            de_o        <= 1'b0;
            hsync_o     <= 1'b0;
            vsync_o     <= 1'b0;
        end else begin
            if (prod_i.de) begin
                blend_rgb_o <= rgb_t'(nib_d);
            end else begin
                blend_rgb_o <= '0;          // blanking
            end
            de_o    <= prod_i.de;
            hsync_o <= prod_i.hsync;
            vsync_o <= prod_i.vsync;
        end
    end

endmodule

// ==== hw/blend_pkg.sv ====
// pixel blender shared types, pipeline widths and alpha mode codes
package blend_pkg;

    typedef logic [3:0]  nib_t;             // 4-bit color or alpha nibble
    typedef logic [7:0]  byte_t;            // expanded channel or alpha weight
    typedef logic [15:0] word_t;            // 8x8 product

    // input pixel, ARGB 4:4:4:4
    typedef struct packed {
        nib_t a;                            // B: alpha, A: clamp + mode in [3:2]
        nib_t r;                            // red
        nib_t g;                            // green
        nib_t b;                            // blue
    } argb_t;

    // output pixel, RGB 4:4:4
    typedef struct packed {
        nib_t r;                            // red
        nib_t g;                            // green
        nib_t b;                            // blue
    } rgb_t;

    localparam int NUM_CHAN   = 3;          // red, green, blue
    localparam int PROD_SHIFT = 9;          // lsb of kept product field
    localparam int SUM_W      = 8;          // two 7-bit fields plus carry

    localparam logic [SUM_W-2:0] SAT_VAL = 7'h7F;   // clamped channel value

    localparam byte_t ALPHA_FULL = 8'hFF;   // layer fully weighted
    localparam byte_t ALPHA_NONE = 8'h00;   // layer dropped

    // A alpha nibble [3:2] selects how the layers combine
    localparam logic [1:0] MODE_BLEND     = 2'b00;  // A*(1-aB) + B*aB
    localparam logic [1:0] MODE_ADD_WRAP  = 2'b01;  // A + B*aB, wraps
    localparam logic [1:0] MODE_ADD_CLAMP = 2'b10;  // A + B*aB, saturates
    localparam logic [1:0] MODE_OPAQUE    = 2'b11;  // A only

    localparam int PIPE_LAT = 3;            // unpack, multiply, sum

endpackage

// ==== hw/blend_prod_if.sv ====
// stage 2 bundle, scaled channel products heading into the sum and clamp logic
`timescale 1ns/1ps

interface blend_prod_if
    import blend_pkg::*;
();

    word_t [NUM_CHAN-1:0] prod_a;           // A channel * alpha_a, [2] red
    word_t [NUM_CHAN-1:0] prod_b;           // B channel * alpha_b, [2] red
    logic                 clamp;            // saturate sum instead of wrap
    logic                 de;               // display enable
    logic                 hsync;            // horizontal sync
    logic                 vsync;            // vertical sync

    // mixer side
    modport src (
        output prod_a,
        output prod_b,
        output clamp,
        output de,
        output hsync,
        output vsync
    );

    // output side
    modport dst (
        input  prod_a,
        input  prod_b,
        input  clamp,
        input  de,
        input  hsync,
        input  vsync
    );

endinterface

// ==== hw/blend_stage_if.sv ====
// stage 1 bundle, unpacked colors and alpha weights heading into the multipliers
`timescale 1ns/1ps

interface blend_stage_if
    import blend_pkg::*;
();

    byte_t [NUM_CHAN-1:0] col_a;            // layer A channels, [2] red .. [0] blue
    byte_t [NUM_CHAN-1:0] col_b;            // layer B channels, same order
    byte_t                alpha_a;          // weight applied to A
    byte_t                alpha_b;          // weight applied to B
    logic                 clamp;            // saturate sum instead of wrap
    logic                 de;               // display enable
    logic                 hsync;            // horizontal sync
    logic                 vsync;            // vertical sync

    // unpack side
    modport src (
        output col_a,
        output col_b,
        output alpha_a,
        output alpha_b,
        output clamp,
        output de,
        output hsync,
        output vsync
    );

    // mixer side
    modport dst (
        input  col_a,
        input  col_b,
        input  alpha_a,
        input  alpha_b,
        input  clamp,
        input  de,
        input  hsync,
        input  vsync
    );

endinterface

// ==== hw/blend_unpack.sv ====
// input stage, expands nibbles to bytes and selects the per-layer alpha weights
`timescale 1ns/1ps

module blend_unpack
    import blend_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  argb_t       color_a_i,          // foreground, alpha nibble holds mode
    input  argb_t       color_b_i,          // background, alpha nibble is weight
    input  logic        de_i,
    input  logic        hsync_i,
    input  logic        vsync_i,
    blend_stage_if.src  stage_o
);

    // replicate so 0x0 -> 0x00 and 0xF -> 0xFF
    function automatic byte_t expand(input nib_t n);
        return {n, n};
    endfunction

    logic [1:0]           mode;             // A mode bits
    nib_t                 alpha_nib_b;      // raw B alpha
    byte_t                alpha_a_d;        // next A weight
    byte_t                alpha_b_d;        // next B weight
    byte_t [NUM_CHAN-1:0] col_a_d;          // next A channels
    byte_t [NUM_CHAN-1:0] col_b_d;          // next B channels

    assign mode        = color_a_i.a[3:2];
    assign alpha_nib_b = color_b_i.a;

    // red ends up in the top slot
    assign col_a_d = {expand(color_a_i.r), expand(color_a_i.g), expand(color_a_i.b)};
    assign col_b_d = {expand(color_b_i.r), expand(color_b_i.g), expand(color_b_i.b)};

    always_comb begin
        alpha_a_d = ALPHA_FULL;             // A opaque unless blending
        alpha_b_d = expand(alpha_nib_b);
        case (mode)
            MODE_BLEND: begin
                alpha_a_d = expand(~alpha_nib_b);   // complement of B weight
                alpha_b_d = expand(alpha_nib_b);
            end
            MODE_ADD_WRAP, MODE_ADD_CLAMP: begin
                alpha_a_d = ALPHA_FULL;     // A at full strength
                alpha_b_d = expand(alpha_nib_b);
            end
            MODE_OPAQUE: begin
                alpha_a_d = ALPHA_FULL;
                alpha_b_d = ALPHA_NONE;     // B hidden
            end
        endcase
    end

    // stage 1 register, colors and timing move together
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_o.col_a   <= '0;
            stage_o.col_b   <= '0;
            stage_o.alpha_a <= '0;
            stage_o.alpha_b <= '0;
            stage_o.clamp   <= 1'b0;
            stage_o.de      <= 1'b0;
            stage_o.hsync   <= 1'b0;
            stage_o.vsync   <= 1'b0;
        end else begin
            stage_o.col_a   <= col_a_d;
            stage_o.col_b   <= col_b_d;
            stage_o.alpha_a <= alpha_a_d;
            stage_o.alpha_b <= alpha_b_d;
            stage_o.clamp   <= color_a_i.a[3];      // A bit 15
            stage_o.de      <= de_i;
            stage_o.hsync   <= hsync_i;
            stage_o.vsync   <= vsync_i;
        end
    end

endmodule

// ==== hw/channel_mult.sv ====
// one color channel, registered A and B products against their alpha weights
`timescale 1ns/1ps

module channel_mult
    import blend_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,
    input  byte_t   col_a_i,                // A channel, expanded
    input  byte_t   col_b_i,                // B channel, expanded
    input  byte_t   alpha_a_i,              // A weight
    input  byte_t   alpha_b_i,              // B weight
    output word_t   prod_a_o,               // col_a * alpha_a
    output word_t   prod_b_o                // col_b * alpha_b
);

    word_t prod_a_d;                        // unregistered A product
    word_t prod_b_d;                        // unregistered B product

    // unsigned 8x8, full 16-bit result
    assign prod_a_d = word_t'(col_a_i) * word_t'(alpha_a_i);
    assign prod_b_d = word_t'(col_b_i) * word_t'(alpha_b_i);

    // output register, one pair per channel
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prod_a_o <= '0;
            prod_b_o <= '0;
        end else begin
            prod_a_o <= prod_a_d;
            prod_b_o <= prod_b_d;
        end
    end

endmodule

// ==== hw/video_blend.sv ====
// two-layer ARGB pixel blender, three-stage pipeline with sync carried alongside
`timescale 1ns/1ps

module video_blend
    import blend_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,
    input  argb_t   color_a_i,              // foreground, mode in alpha nibble
    input  argb_t   color_b_i,              // background with alpha
    input  logic    de_i,
    input  logic    hsync_i,
    input  logic    vsync_i,
    output rgb_t    blend_rgb_o,            // result, PIPE_LAT cycles later
    output logic    de_o,
    output logic    hsync_o,
    output logic    vsync_o
);

    blend_stage_if stage_if ();             // unpack -> mix
    blend_prod_if  prod_if ();              // mix -> output

    // stage 1
    blend_unpack u_unpack (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .color_a_i (color_a_i),
        .color_b_i (color_b_i),
        .de_i      (de_i),
        .hsync_i   (hsync_i),
        .vsync_i   (vsync_i),
        .stage_o   (stage_if.src)
    );

    // stage 2
    blend_mix u_mix (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .stage_i   (stage_if.dst),
        .prod_o    (prod_if.src)
    );

    // stage 3
    blend_output u_output (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .prod_i      (prod_if.dst),
        .blend_rgb_o (blend_rgb_o),
        .de_o        (de_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the blender testbench with Verilator and run it, exit status is the result
cd "$(dirname "$0")" \
    && verilator --binary --timing -j 0 -f build.f --top-module tb_video_blend \
        -o sim_video_blend \
    && ./obj_dir/sim_video_blend \
    || exit 1
